/* mpmc_pkg.sv */
package mpmc_pkg;

	// ====================
	// Controller geometry
	// ====================

	// Number of client ports sharing the memory
	localparam int NUM_PORTS = 4;
	localparam int PORT_W = 2;
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	typedef logic [PORT_W-1:0] port_id_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// Command that travels with every request
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} op_e;

	// Per-port request sequencer in the clk domain
	typedef enum logic [1:0] {
		PS_IDLE         = 2'd0,
		PS_WAIT_GRANT   = 2'd1,
		PS_WAIT_DONE    = 2'd2,
		PS_WAIT_RELEASE = 2'd3
	} port_state_e;

	// Memory controller sequencer
	typedef enum logic {
		MC_IDLE = 1'b0,
		MC_BUSY = 1'b1
	} mc_state_e;

endpackage

/* mpmc_req_if.sv */
`timescale 1ns/1ps

// One port's request toward the arbiter, all in the clk domain
interface mpmc_req_if;

	// Request level, held until the arbiter grants it
	logic req;
	mpmc_pkg::op_e op;
	mpmc_pkg::addr_t addr;
	mpmc_pkg::data_t wdata;

	// Single clk cycle pulse to the winning port
	logic grant;

	modport port (
		output req,
		output op,
		output addr,
		output wdata,
		input  grant
	);

	modport arb (
		input  req,
		input  op,
		input  addr,
		input  wdata,
		output grant
	);

endinterface

/* mpmc_od_ack.sv */
`timescale 1ns/1ps

// Completion acknowledge for one port
// A done tagged for this port is stretched in clk so that the slower pclk
// is sure to sample it, then it is synchronized and edge detected in pclk
module mpmc_od_ack #(
	parameter mpmc_pkg::port_id_t PORT_ID = '0,
	parameter int STRETCH = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               pclk,
	input  logic               done,
	input  mpmc_pkg::port_id_t done_port,
	output logic               ack_pulse
);

	logic [STRETCH-1:0] stretch_q;
	logic               ack_lvl;
	logic [2:0]         psync_q;

	// ====================
	// clk domain stretch
	// ====================

	// A tag match fills the shift register with ones, which then drain out
	// one per cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			stretch_q <= '0;
		end else if (done && done_port == PORT_ID) begin
			stretch_q <= '1;
		end else begin
			stretch_q <= stretch_q >> 1;
		end
	end

	// The low bit stays high for STRETCH cycles and comes straight from a flop
	assign ack_lvl = stretch_q[0];

	// ====================
	// pclk domain edge
	// ====================

	// Two stages of synchronizer and a third stage that remembers the last value
	always_ff @(posedge pclk) begin
		if (rst) begin
			psync_q <= '0;
		end else begin
			psync_q <= {psync_q[1:0], ack_lvl};
		end
	end

	// Rising edge of the synchronized level gives one pclk cycle of pulse
	assign ack_pulse = psync_q[1] & ~psync_q[2];

endmodule

/* mpmc_port.sv */
`timescale 1ns/1ps

// Port front end
// Crosses the client's four-phase request into clk, presents it to the
// arbiter and holds the result until the client releases req
module mpmc_port #(
	parameter mpmc_pkg::port_id_t PORT_ID = '0,
	parameter int STRETCH = 6
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               pclk,
	input  logic               p_req,
	input  mpmc_pkg::op_e      p_op,
	input  mpmc_pkg::addr_t    p_addr,
	input  mpmc_pkg::data_t    p_wdata,
	input  logic               done,
	input  mpmc_pkg::port_id_t done_port,
	input  mpmc_pkg::data_t    rdata,
	output logic               p_ack,
	output mpmc_pkg::data_t    p_rdata,
	mpmc_req_if.port           rq
);

	logic [1:0]            req_sync_q;
	logic                  req_s;
	logic                  tag_hit;
	logic                  ack_pulse;
	mpmc_pkg::port_state_e state_q;
	mpmc_pkg::data_t       rdata_q;

	// Synchronized request level
	assign req_s = req_sync_q[1];

	// The broadcast completion belongs to this port
	assign tag_hit = done && (done_port == PORT_ID) && (state_q == mpmc_pkg::PS_WAIT_DONE);

	// ====================
	// clk domain sequencer
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			req_sync_q <= '0;
			state_q <= mpmc_pkg::PS_IDLE;
			rq.req <= 1'b0;
		end else begin
			req_sync_q <= {req_sync_q[0], p_req};
			case (state_q)
				mpmc_pkg::PS_IDLE: begin
					if (req_s) begin
						rq.req <= 1'b1;
						state_q <= mpmc_pkg::PS_WAIT_GRANT;
					end
				end
				mpmc_pkg::PS_WAIT_GRANT: begin
					// Grant lasts one cycle so the request comes down right after it
					if (rq.grant) begin
						rq.req <= 1'b0;
						state_q <= mpmc_pkg::PS_WAIT_DONE;
					end
				end
				mpmc_pkg::PS_WAIT_DONE: begin
					if (tag_hit) begin
						state_q <= mpmc_pkg::PS_WAIT_RELEASE;
					end
				end
				mpmc_pkg::PS_WAIT_RELEASE: begin
					// The client only drops req once it has seen ack
					if (!req_s) begin
						state_q <= mpmc_pkg::PS_IDLE;
					end
				end
				default: state_q <= mpmc_pkg::PS_IDLE;
			endcase
		end
	end

	// Command fields are stable while req is high, so they are taken as a bundle
	always_ff @(posedge clk) begin
		if (state_q == mpmc_pkg::PS_IDLE && req_s) begin
			rq.op <= p_op;
			rq.addr <= p_addr;
			rq.wdata <= p_wdata;
		end
		if (tag_hit) begin
			rdata_q <= rdata;
		end
	end

	// Read data is held from done until the next request, which covers the ack window
	assign p_rdata = rdata_q;

	// ====================
	// pclk domain ack
	// ====================

	mpmc_od_ack #(
		.PORT_ID (PORT_ID),
		.STRETCH (STRETCH)
	) ack_i (
		.clk       (clk),
		.rst       (rst),
		.pclk      (pclk),
		.done      (done),
		.done_port (done_port),
		.ack_pulse (ack_pulse)
	);

	// Ack rises on the completion pulse and falls once req is gone
	always_ff @(posedge pclk) begin
		if (rst) begin
			p_ack <= 1'b0;
		end else if (!p_req) begin
			p_ack <= 1'b0;
		end else if (ack_pulse) begin
			p_ack <= 1'b1;
		end
	end

endmodule

/* mpmc_arbiter.sv */
`timescale 1ns/1ps

// Round-robin arbiter
// Issues one grant at a time and only while the memory controller is idle
module mpmc_arbiter #(
	parameter int NUM_PORTS = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               idle,
	mpmc_req_if.arb            rq [NUM_PORTS],
	output logic               start,
	output mpmc_pkg::port_id_t start_port,
	output mpmc_pkg::op_e      op,
	output mpmc_pkg::addr_t    addr,
	output mpmc_pkg::data_t    wdata
);

	logic [NUM_PORTS-1:0] req_v;
	logic [NUM_PORTS-1:0] grant_q;
	mpmc_pkg::op_e        op_v [NUM_PORTS];
	mpmc_pkg::addr_t      addr_v [NUM_PORTS];
	mpmc_pkg::data_t      wdata_v [NUM_PORTS];
	mpmc_pkg::port_id_t   last_q;
	mpmc_pkg::port_id_t   win_port;
	logic                 win_valid;
	logic                 issue;

	// Interface array elements need constant indices, so flatten them here
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_rq
		assign req_v[i] = rq[i].req;
		assign op_v[i] = rq[i].op;
		assign addr_v[i] = rq[i].addr;
		assign wdata_v[i] = rq[i].wdata;
		assign rq[i].grant = grant_q[i];
	end

	// Search from just past the last winner
	// Walking the distance downward leaves the nearest requester as the winner
	always_comb begin
		int idx;
		win_valid = 1'b0;
		win_port = last_q;
		for (int k = NUM_PORTS; k >= 1; k--) begin
			idx = (int'(last_q) + k) % NUM_PORTS;
			if (req_v[idx]) begin
				win_valid = 1'b1;
				win_port = mpmc_pkg::port_id_t'(idx);
			end
		end
	end

	// No new grant in the start cycle since idle only falls one cycle later
	assign issue = win_valid && idle && !start;

	always_ff @(posedge clk) begin
		if (rst) begin
			grant_q <= '0;
			start <= 1'b0;
			last_q <= mpmc_pkg::port_id_t'(NUM_PORTS - 1);
		end else begin
			grant_q <= '0;
			start <= issue;
			if (issue) begin
				grant_q[win_port] <= 1'b1;
				last_q <= win_port;
			end
		end
	end

	// Winner's command is registered alongside start
	always_ff @(posedge clk) begin
		if (issue) begin
			start_port <= win_port;
			op <= op_v[win_port];
			addr <= addr_v[win_port];
			wdata <= wdata_v[win_port];
		end
	end

endmodule

/* mpmc_mem_ctrl.sv */
`timescale 1ns/1ps

// On-chip memory with a fixed access latency
// MEM_LAT must be at least 2
module mpmc_mem_ctrl #(
	parameter int MEM_LAT = 3
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  mpmc_pkg::port_id_t start_port,
	input  mpmc_pkg::op_e      op,
	input  mpmc_pkg::addr_t    addr,
	input  mpmc_pkg::data_t    wdata,
	output logic               idle,
	output logic               done,
	output mpmc_pkg::port_id_t done_port,
	output mpmc_pkg::data_t    rdata
);

	localparam int DEPTH = 2 ** mpmc_pkg::ADDR_W;
	localparam int CNT_W = $clog2(MEM_LAT + 1);

	mpmc_pkg::data_t     mem [DEPTH];
	mpmc_pkg::mc_state_e state_q;
	logic [CNT_W-1:0]    lat_q;
	logic                clr_active_q;
	mpmc_pkg::addr_t     clr_addr_q;
	logic                wr_en;
	mpmc_pkg::addr_t     wr_addr;
	mpmc_pkg::data_t     wr_data;

	// Not idle while busy or while the clear sweep is still running
	assign idle = (state_q == mpmc_pkg::MC_IDLE) && !clr_active_q;

	// The clear sweep owns the write port until it finishes
	assign wr_en = clr_active_q || (start && op == mpmc_pkg::OP_WRITE);
	assign wr_addr = clr_active_q ? clr_addr_q : addr;
	assign wr_data = clr_active_q ? '0 : wdata;

	// ====================
	// Storage
	// ====================

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		// Reads are sampled at start and held until done
		if (start) begin
			rdata <= mem[addr];
			done_port <= start_port;
		end
	end

	// ====================
	// Sequencer
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= mpmc_pkg::MC_IDLE;
			lat_q <= '0;
			done <= 1'b0;
			clr_active_q <= 1'b1;
			clr_addr_q <= '0;
		end else begin
			done <= 1'b0;
			if (clr_active_q) begin
				clr_addr_q <= clr_addr_q + 1'b1;
				// Last word of the sweep
				if (clr_addr_q == '1) begin
					clr_active_q <= 1'b0;
				end
			end
			case (state_q)
				mpmc_pkg::MC_IDLE: begin
					if (start) begin
						lat_q <= CNT_W'(MEM_LAT - 1);
						state_q <= mpmc_pkg::MC_BUSY;
					end
				end
				mpmc_pkg::MC_BUSY: begin
					// done lands MEM_LAT cycles after the start cycle
					if (lat_q == CNT_W'(1)) begin
						done <= 1'b1;
						state_q <= mpmc_pkg::MC_IDLE;
					end else begin
						lat_q <= lat_q - 1'b1;
					end
				end
				default: state_q <= mpmc_pkg::MC_IDLE;
			endcase
		end
	end

endmodule

/* mpmc_top.sv */
`timescale 1ns/1ps

// Multi-port memory controller
// Peer ports in the pclk domain share one memory through round robin
module mpmc_top #(
	parameter int NUM_PORTS = mpmc_pkg::NUM_PORTS,
	parameter int MEM_LAT = 3,
	parameter int STRETCH = 6
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  pclk,
	input  logic [NUM_PORTS-1:0]                  p_req,
	input  logic [NUM_PORTS-1:0]                  p_op,
	input  mpmc_pkg::addr_t [NUM_PORTS-1:0]       p_addr,
	input  mpmc_pkg::data_t [NUM_PORTS-1:0]       p_wdata,
	output logic [NUM_PORTS-1:0]                  p_ack,
	output mpmc_pkg::data_t [NUM_PORTS-1:0]       p_rdata
);

	// Arbiter to memory controller
	logic               start;
	mpmc_pkg::port_id_t start_port;
	mpmc_pkg::op_e      op;
	mpmc_pkg::addr_t    addr;
	mpmc_pkg::data_t    wdata;
	logic               idle;

	// Completion broadcast to every port
	logic               done;
	mpmc_pkg::port_id_t done_port;
	mpmc_pkg::data_t    rdata;

	mpmc_req_if rq_if [NUM_PORTS] ();

	// ====================
	// Port front ends
	// ====================

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
		mpmc_port #(
			.PORT_ID (mpmc_pkg::port_id_t'(i)),
			.STRETCH (STRETCH)
		) port_i (
			.clk       (clk),
			.rst       (rst),
			.pclk      (pclk),
			.p_req     (p_req[i]),
			.p_op      (mpmc_pkg::op_e'(p_op[i])),
			.p_addr    (p_addr[i]),
			.p_wdata   (p_wdata[i]),
			.done      (done),
			.done_port (done_port),
			.rdata     (rdata),
			.p_ack     (p_ack[i]),
			.p_rdata   (p_rdata[i]),
			.rq        (rq_if[i])
		);
	end

	// ====================
	// Shared back end
	// ====================

	mpmc_arbiter #(
		.NUM_PORTS (NUM_PORTS)
	) arb_i (
		.clk        (clk),
		.rst        (rst),
		.idle       (idle),
		.rq         (rq_if),
		.start      (start),
		.start_port (start_port),
		.op         (op),
		.addr       (addr),
		.wdata      (wdata)
	);

	mpmc_mem_ctrl #(
		.MEM_LAT (MEM_LAT)
	) mc_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.start_port (start_port),
		.op         (op),
		.addr       (addr),
		.wdata      (wdata),
		.idle       (idle),
		.done       (done),
		.done_port  (done_port),
		.rdata      (rdata)
	);

endmodule

/* mpmc_asserts.sv */
`timescale 1ns/1ps

// Protocol checks on the controller, bound into mpmc_top
module mpmc_asserts #(
	parameter int NUM_PORTS = 4
) (
	input logic                 clk,
	input logic                 rst,
	input logic                 pclk,
	input logic [NUM_PORTS-1:0] req,
	input logic [NUM_PORTS-1:0] grant,
	input logic                 start,
	input logic                 idle,
	input logic                 done,
	input mpmc_pkg::port_id_t   done_port,
	input logic [NUM_PORTS-1:0] p_req,
	input logic [NUM_PORTS-1:0] p_ack
);

	logic [NUM_PORTS-1:0] served_q;

	// At most one port holds grant in any cycle, and only a port that still requests
	assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant) && ((grant & ~req) == '0))
		else $error("grant is not one-hot or went to a port without a request");

	// The arbiter may only start an access on an idle controller
	assert property (@(posedge clk) disable iff (rst) start |-> idle)
		else $error("start issued while the memory controller was not idle");

	// A port counts as served from its tagged done until the client drops req
	always_ff @(posedge clk) begin
		if (rst) begin
			served_q <= '0;
		end else begin
			for (int q = 0; q < NUM_PORTS; q++) begin
				if (!p_req[q]) begin
					served_q[q] <= 1'b0;
				end else if (done && done_port == mpmc_pkg::port_id_t'(q)) begin
					served_q[q] <= 1'b1;
				end
			end
		end
	end

	// Ack may only rise for a request that the memory has already completed
	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_ack
		assert property (@(posedge pclk) disable iff (rst) $rose(p_ack[i]) |-> served_q[i])
			else $error("ack on port %0d rose before its request was served", i);
	end

endmodule

bind mpmc_top mpmc_asserts #(
	.NUM_PORTS (NUM_PORTS)
) asserts_i (
	.clk       (clk),
	.rst       (rst),
	.pclk      (pclk),
	.req       (arb_i.req_v),
	.grant     (arb_i.grant_q),
	.start     (start),
	.idle      (idle),
	.done      (done),
	.done_port (done_port),
	.p_req     (p_req),
	.p_ack     (p_ack)
);

/* mpmc_tb.sv */
`timescale 1ns/1ps

module mpmc_tb;

	localparam int NUM_PORTS = mpmc_pkg::NUM_PORTS;
	localparam int MAX_LINES = 64;

	logic                            clk;
	logic                            rst;
	logic                            pclk;
	logic [NUM_PORTS-1:0]            p_req;
	logic [NUM_PORTS-1:0]            p_op;
	mpmc_pkg::addr_t [NUM_PORTS-1:0] p_addr;
	mpmc_pkg::data_t [NUM_PORTS-1:0] p_wdata;
	logic [NUM_PORTS-1:0]            p_ack;
	mpmc_pkg::data_t [NUM_PORTS-1:0] p_rdata;

	// One entry per trace line, plus the idle gap drawn for it
	int              t_group [MAX_LINES];
	int              t_port [MAX_LINES];
	mpmc_pkg::op_e   t_op [MAX_LINES];
	mpmc_pkg::addr_t t_addr [MAX_LINES];
	mpmc_pkg::data_t t_wdata [MAX_LINES];
	mpmc_pkg::data_t t_exp [MAX_LINES];
	int              t_gap [MAX_LINES];
	int              n_lines;
	integer          seed;
	int              cycles;
	int              timeout_limit;

	mpmc_top #(
		.NUM_PORTS (NUM_PORTS),
		.MEM_LAT   (3),
		.STRETCH   (6)
	) dut_i (
		.clk     (clk),
		.rst     (rst),
		.pclk    (pclk),
		.p_req   (p_req),
		.p_op    (p_op),
		.p_addr  (p_addr),
		.p_wdata (p_wdata),
		.p_ack   (p_ack),
		.p_rdata (p_rdata)
	);

	// ====================
	// Clocks and timeout
	// ====================

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Port clock, unrelated in phase to clk except at common multiples
	initial begin
		pclk = 1'b0;
		forever #10 pclk = ~pclk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_limit) begin
			abort_run($sformatf("Timeout: run still busy after %0d clk cycles", cycles));
		end
	end

	// ====================
	// Checks
	// ====================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_rdata(input mpmc_pkg::data_t got, input mpmc_pkg::data_t exp,
			input string what);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t ns: %s read %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_ack(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH at %0t ns: %s ack is %b, expected %b",
				$time, what, got, exp));
		end
	endtask

	// One four-phase transaction from the client side of a port
	task automatic run_client(input int k);
		int port;
		int waited;
		port = t_port[k];
		// Idle gap, the port must stay quiet while no req is up
		repeat (t_gap[k]) begin
			@(posedge pclk);
			if (p_ack[port]) begin
				abort_run($sformatf("Ack appeared on port %0d with no request raised", port));
			end
		end
		@(posedge pclk);
		#1;
		p_op[port] = t_op[k];
		p_addr[port] = t_addr[k];
		p_wdata[port] = t_wdata[k];
		p_req[port] = 1'b1;
		do begin
			@(posedge pclk);
		end while (!p_ack[port]);
		// Read data is valid for as long as ack is high
		if (t_op[k] == mpmc_pkg::OP_READ) begin
			check_rdata(p_rdata[port], t_exp[k],
				$sformatf("port %0d addr %h", port, t_addr[k]));
		end
		#1;
		p_req[port] = 1'b0;
		waited = 0;
		do begin
			@(posedge pclk);
			waited++;
			if (waited > 4) begin
				abort_run($sformatf("Ack on port %0d stayed high after req fell", port));
			end
		end while (p_ack[port]);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		int fd;
		int code;
		int g;
		int p;
		int o;
		int idx;
		int j;
		mpmc_pkg::addr_t a;
		mpmc_pkg::data_t w;
		mpmc_pkg::data_t e;
		logic [8*256-1:0] skip_line;
		rst = 1'b1;
		p_req = '0;
		p_op = '0;
		p_addr = '0;
		p_wdata = '0;
		cycles = 0;
		timeout_limit = 300 * MAX_LINES;
		seed = 62165;
		n_lines = 0;
		fd = $fopen("mpmc_trace.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open the trace file mpmc_trace.txt");
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%h %h %h %h %h %h\n", g, p, o, a, w, e);
			if (code == 6) begin
				if (n_lines >= MAX_LINES || p >= NUM_PORTS) begin
					abort_run("Trace has too many lines or a port number out of range");
				end
				t_group[n_lines] = g;
				t_port[n_lines] = p;
				t_op[n_lines] = mpmc_pkg::op_e'(o[0]);
				t_addr[n_lines] = a;
				t_wdata[n_lines] = w;
				t_exp[n_lines] = e;
				// Gaps are drawn in file order so the run repeats exactly
				t_gap[n_lines] = $unsigned($random(seed)) % 4;
				n_lines++;
			end else begin
				// Comment line, skip the rest of it
				code = $fgets(skip_line, fd);
			end
		end
		$fclose(fd);
		timeout_limit = 300 * (n_lines + 1);

		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int q = 0; q < NUM_PORTS; q++) begin
			check_ack(p_ack[q], 1'b0, $sformatf("after reset, port %0d", q));
		end

		// Lines of one group run side by side, the groups one after another
		idx = 0;
		while (idx < n_lines) begin
			j = idx;
			while (j < n_lines && t_group[j] == t_group[idx]) begin
				automatic int k = j;
				fork
					run_client(k);
				join_none
				j++;
			end
			wait fork;
			#1;
			for (int q = 0; q < NUM_PORTS; q++) begin
				check_ack(p_ack[q], 1'b0, $sformatf("after group %0d, port %0d", t_group[idx], q));
			end
			idx = j;
		end

		$display("Test passed");
		$finish;
	end

endmodule

/* mpmc_trace.txt */
# group port op addr wdata expected, all hex; op 0 is read, 1 is write
# expected read data is ignored on writes
0 0 0 10 00000000 00000000
0 2 0 ff 00000000 00000000
1 1 1 20 deadbeef 00000000
2 1 0 20 00000000 deadbeef
3 0 1 40 11110000 00000000
3 1 1 41 22221111 00000000
3 2 1 42 33332222 00000000
3 3 1 43 44443333 00000000
4 0 0 41 00000000 22221111
4 1 0 42 00000000 33332222
4 2 0 43 00000000 44443333
4 3 0 40 00000000 11110000
5 2 1 80 aaaa0001 00000000
6 0 1 80 bbbb0002 00000000
6 3 0 41 00000000 22221111
7 1 1 80 cccc0003 00000000
8 3 0 80 00000000 cccc0003
8 0 0 42 00000000 33332222
8 2 1 43 55554444 00000000
9 0 0 43 00000000 55554444
9 1 0 80 00000000 cccc0003
9 2 0 20 00000000 deadbeef
9 3 0 10 00000000 00000000
a 3 1 05 12345678 00000000
b 1 0 05 00000000 12345678
b 2 0 80 00000000 cccc0003

/* mpmc_top.f */
mpmc_pkg.sv
mpmc_req_if.sv
mpmc_od_ack.sv
mpmc_port.sv
mpmc_arbiter.sv
mpmc_mem_ctrl.sv
mpmc_top.sv
mpmc_asserts.sv
mpmc_tb.sv

/* Makefile */
TOP = mpmc_tb

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f mpmc_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
